// File: lsu_top.f
rtl/lsu_pkg.sv
rtl/lsu_req_if.sv
rtl/lsu_rsp_if.sv
rtl/lsu_req_align.sv
rtl/lsu_txn_ctrl.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
tb/lsu_top_asserts.sv
tb/tb_lsu_top.sv

// File: rtl/lsu_pkg.sv
//////////////////////////////
// Load/store unit shared widths, size codes and read word view
//////////////////////////////
package lsu_pkg;

  // Bus widths
  localparam int lsu_addr_w = 32;
  localparam int lsu_data_w = 32;
  localparam int lsu_be_w   = 4;

  // Outstanding transfer limit and its counter width
  localparam int lsu_depth  = 2;
  localparam int lsu_cnt_w  = 2;

  //////////////////////////////
  // Access size codes
  //////////////////////////////
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } lsu_size_e;

  //////////////////////////////
  // Read word, seen as bytes or as halfwords
  //////////////////////////////
  typedef union packed {
    // Byte lanes, index 0 is the lowest byte
    logic [3:0][7:0]  bytes;
    // Halfword lanes
    logic [1:0][15:0] halves;
  } lsu_word_u;

endpackage

// File: rtl/lsu_rdata_align.sv
`timescale 1ns/1ps
//////////////////////////////
// Read data alignment
// Merges split halves, realigns and extends the result
//////////////////////////////
module lsu_rdata_align (
  input  logic                           clk,
  input  logic                           rst_n,
  lsu_rsp_if.dst                         rsp,
  output logic                           rsp_valid_o,
  output logic [lsu_pkg::lsu_data_w-1:0] rsp_rdata_o
);
  import lsu_pkg::*;

  // Low word of a split read
  logic [lsu_data_w-1:0]   rdata_lo_q;
  // A first half has returned and waits for its partner
  logic                    half_q;
  logic [2*lsu_data_w-1:0] rdata_full;
  logic [2*lsu_data_w-1:0] rdata_shift;
  lsu_word_u               rdata_w;
  logic                    sign_bit;

  //////////////////////////////
  // First half capture
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_q <= 1'b0;
    end else if (rsp.rvalid) begin
      half_q <= !rsp.last;
    end
  end

  // Only reads carry data worth keeping
  always_ff @(posedge clk) begin
    if (rsp.rvalid && !rsp.last && !rsp.we) begin
      rdata_lo_q <= rsp.rdata;
    end
  end

  //////////////////////////////
  // Realign and extend
  //////////////////////////////
  // Unsplit reads repeat the word so the shift still fills the top
  assign rdata_full  = half_q ? {rsp.rdata, rdata_lo_q} : {rsp.rdata, rsp.rdata};
  assign rdata_shift = rdata_full >> {rsp.off, 3'b000};
  assign rdata_w     = rdata_shift[lsu_data_w-1:0];

  always_comb begin
    case (rsp.size)
      size_byte: begin
        sign_bit    = rsp.sext && rdata_w.bytes[0][7];
        rsp_rdata_o = {{24{sign_bit}}, rdata_w.bytes[0]};
      end
      size_half: begin
        sign_bit    = rsp.sext && rdata_w.halves[0][15];
        rsp_rdata_o = {{16{sign_bit}}, rdata_w.halves[0]};
      end
      default: begin
        // Full word, no extension
        sign_bit    = 1'b0;
        rsp_rdata_o = rdata_w;
      end
    endcase
  end

  // One result per access, on its last response
  assign rsp_valid_o = rsp.rvalid && rsp.last;

endmodule

// File: rtl/lsu_req_align.sv
`timescale 1ns/1ps
//////////////////////////////
// Request alignment
// Address, byte enables, lane data and split state per transfer
//////////////////////////////
module lsu_req_align (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req_valid_i,
  input  logic [lsu_pkg::lsu_addr_w-1:0] req_op_a_i,
  input  logic [lsu_pkg::lsu_addr_w-1:0] req_op_b_i,
  input  lsu_pkg::lsu_size_e             req_size_i,
  input  logic                           req_sext_i,
  input  logic                           req_we_i,
  input  logic [lsu_pkg::lsu_data_w-1:0] req_wdata_i,
  lsu_req_if.src                         tx
);
  import lsu_pkg::*;

  logic [lsu_addr_w-1:0]   addr;
  logic [lsu_addr_w-1:0]   word_addr;
  logic [1:0]              off;
  logic                    needs_split;
  // Second transfer of a split access is in progress
  logic                    split_q;
  logic [lsu_be_w-1:0]     be_base;
  logic [2*lsu_be_w-1:0]   be_wide;
  logic [2*lsu_data_w-1:0] wdata_wide;

  // Effective address
  assign addr      = req_op_a_i + req_op_b_i;
  assign off       = addr[1:0];
  assign word_addr = {addr[lsu_addr_w-1:2], 2'b00};

  //////////////////////////////
  // Byte enables
  //////////////////////////////
  always_comb begin
    case (req_size_i)
      size_byte: be_base = 4'b0001;
      size_half: be_base = 4'b0011;
      default:   be_base = 4'b1111;
    endcase
  end

  // Low nibble is the first word, high nibble spills into the next word
  assign be_wide = {{lsu_be_w{1'b0}}, be_base} << off;

  // Word off the boundary, or halfword in the top lane
  assign needs_split = ((req_size_i == size_word) && (off != 2'b00)) ||
                       ((req_size_i == size_half) && (off == 2'b11));

  //////////////////////////////
  // Write data lane rotation
  //////////////////////////////
  // Rotate left by 8*off, spilled bytes land in the low lanes
  // which the second half uses
  assign wdata_wide = {req_wdata_i, req_wdata_i} << {off, 3'b000};

  // Transfer outputs
  assign tx.valid = req_valid_i;
  assign tx.addr  = split_q ? word_addr + lsu_addr_w'(4) : word_addr;
  assign tx.be    = split_q ? be_wide[2*lsu_be_w-1:lsu_be_w] : be_wide[lsu_be_w-1:0];
  assign tx.wdata = wdata_wide[2*lsu_data_w-1:lsu_data_w];
  assign tx.we    = req_we_i;
  assign tx.size  = req_size_i;
  assign tx.sext  = req_sext_i;
  assign tx.off   = off;
  // Only the first transfer of a split carries the flag
  assign tx.split = needs_split && !split_q;

  //////////////////////////////
  // Split state
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!req_valid_i) begin
      // Dropped request never leaves a stale second half
      split_q <= 1'b0;
    end else if (tx.valid && tx.ready) begin
      // Set on first half, cleared when the second is taken
      split_q <= tx.split;
    end
  end

endmodule

// File: rtl/lsu_req_if.sv
`timescale 1ns/1ps
//////////////////////////////
// Formed bus transfer, alignment to transfer control
//////////////////////////////
interface lsu_req_if;
  import lsu_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [lsu_addr_w-1:0] addr;
  logic                  we;
  logic [lsu_be_w-1:0]   be;
  logic [lsu_data_w-1:0] wdata;
  lsu_size_e             size;
  logic                  sext;
  logic [1:0]            off;
  // First half of a split, a second transfer follows
  logic                  split;

  modport src (output valid, addr, we, be, wdata, size, sext, off, split, input ready);
  modport dst (input valid, addr, we, be, wdata, size, sext, off, split, output ready);
endinterface

// File: rtl/lsu_rsp_if.sv
`timescale 1ns/1ps
//////////////////////////////
// Returned read word with the attributes of its transfer
//////////////////////////////
interface lsu_rsp_if;
  import lsu_pkg::*;

  logic                  rvalid;
  logic [lsu_data_w-1:0] rdata;
  lsu_size_e             size;
  logic                  sext;
  logic                  we;
  logic [1:0]            off;
  // Final transfer of the access
  logic                  last;

  // No ready, a memory response cannot be stalled
  modport src (output rvalid, rdata, size, sext, we, off, last);
  modport dst (input rvalid, rdata, size, sext, we, off, last);

endinterface

// File: rtl/lsu_top.sv
`timescale 1ns/1ps
//////////////////////////////
// Load/store unit top level
//////////////////////////////
module lsu_top (
  input  logic                           clk,
  input  logic                           rst_n,
  // Request side
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  logic [lsu_pkg::lsu_addr_w-1:0] req_op_a_i,
  input  logic [lsu_pkg::lsu_addr_w-1:0] req_op_b_i,
  input  lsu_pkg::lsu_size_e             req_size_i,
  input  logic                           req_sext_i,
  input  logic                           req_we_i,
  input  logic [lsu_pkg::lsu_data_w-1:0] req_wdata_i,
  // Memory bus
  output logic                           data_req_o,
  input  logic                           data_gnt_i,
  output logic [lsu_pkg::lsu_addr_w-1:0] data_addr_o,
  output logic                           data_we_o,
  output logic [lsu_pkg::lsu_be_w-1:0]   data_be_o,
  output logic [lsu_pkg::lsu_data_w-1:0] data_wdata_o,
  input  logic                           data_rvalid_i,
  input  logic [lsu_pkg::lsu_data_w-1:0] data_rdata_i,
  // Result side
  output logic                           rsp_valid_o,
  output logic [lsu_pkg::lsu_data_w-1:0] rsp_rdata_o,
  output logic                           busy_o
);

  lsu_req_if tx_if ();
  lsu_rsp_if rsp_if ();

  lsu_req_align req_align_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_op_a_i  (req_op_a_i),
    .req_op_b_i  (req_op_b_i),
    .req_size_i  (req_size_i),
    .req_sext_i  (req_sext_i),
    .req_we_i    (req_we_i),
    .req_wdata_i (req_wdata_i),
    .tx          (tx_if.src)
  );

  lsu_txn_ctrl txn_ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .tx            (tx_if.dst),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rsp           (rsp_if.src),
    .req_ready_o   (req_ready_o),
    .busy_o        (busy_o)
  );

  lsu_rdata_align rdata_align_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .rsp         (rsp_if.dst),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

endmodule

// File: rtl/lsu_txn_ctrl.sv
`timescale 1ns/1ps
//////////////////////////////
// Transfer control
// Bus issue, outstanding count and response attribute queue
//////////////////////////////
module lsu_txn_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  lsu_req_if.dst                         tx,
  output logic                           data_req_o,
  input  logic                           data_gnt_i,
  output logic [lsu_pkg::lsu_addr_w-1:0] data_addr_o,
  output logic                           data_we_o,
  output logic [lsu_pkg::lsu_be_w-1:0]   data_be_o,
  output logic [lsu_pkg::lsu_data_w-1:0] data_wdata_o,
  input  logic                           data_rvalid_i,
  input  logic [lsu_pkg::lsu_data_w-1:0] data_rdata_i,
  lsu_rsp_if.src                         rsp,
  output logic                           req_ready_o,
  output logic                           busy_o
);
  import lsu_pkg::*;

  logic [lsu_cnt_w-1:0] cnt_q;
  logic [lsu_cnt_w-1:0] cnt_d;
  logic                 grant;
  // In-order attribute queue, one entry per outstanding transfer
  lsu_size_e            q_size [lsu_depth];
  logic                 q_sext [lsu_depth];
  logic                 q_we   [lsu_depth];
  logic [1:0]           q_off  [lsu_depth];
  logic                 q_last [lsu_depth];
  logic                 wr_ptr_q;
  logic                 rd_ptr_q;

  // Request only while the counter has room
  assign data_req_o   = tx.valid && (cnt_q < lsu_cnt_w'(lsu_depth));
  assign grant        = data_req_o && data_gnt_i;
  assign tx.ready     = grant;
  assign data_addr_o  = tx.addr;
  assign data_we_o    = tx.we;
  assign data_be_o    = tx.be;
  assign data_wdata_o = tx.wdata;

  // Access done when its last transfer is granted
  assign req_ready_o  = grant && !tx.split;
  assign busy_o       = tx.valid || (cnt_q != '0);

  //////////////////////////////
  // Outstanding counter
  //////////////////////////////
  always_comb begin
    case ({grant, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = (cnt_q == '0) ? cnt_q : cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      // Push on grant, pop on response
      if (grant) wr_ptr_q <= ~wr_ptr_q;
      if (data_rvalid_i) rd_ptr_q <= ~rd_ptr_q;
    end
  end

  // Attributes captured with the grant
  always_ff @(posedge clk) begin
    if (grant) begin
      q_size[wr_ptr_q] <= tx.size;
      q_sext[wr_ptr_q] <= tx.sext;
      q_we[wr_ptr_q]   <= tx.we;
      q_off[wr_ptr_q]  <= tx.off;
      q_last[wr_ptr_q] <= !tx.split;
    end
  end

  // Head of queue travels with the response
  assign rsp.rvalid = data_rvalid_i;
  assign rsp.rdata  = data_rdata_i;
  assign rsp.size   = q_size[rd_ptr_q];
  assign rsp.sext   = q_sext[rd_ptr_q];
  assign rsp.we     = q_we[rd_ptr_q];
  assign rsp.off    = q_off[rd_ptr_q];
  assign rsp.last   = q_last[rd_ptr_q];

endmodule

// File: tb/lsu_top_asserts.sv
`timescale 1ns/1ps
//////////////////////////////
// Bound checks for the load/store unit
// Bus rules and expected results from the memory pattern
//////////////////////////////
module lsu_top_asserts (
  input logic               clk,
  input logic               rst_n,
  input logic               req_valid_i,
  input logic               req_ready_o,
  input logic               req_sext_i,
  input logic               req_we_i,
  input logic [31:0]        req_op_a_i,
  input logic [31:0]        req_op_b_i,
  input logic [31:0]        req_wdata_i,
  input lsu_pkg::lsu_size_e req_size_i,
  input logic               data_req_o,
  input logic               data_gnt_i,
  input logic               data_we_o,
  input logic               data_rvalid_i,
  input logic [31:0]        data_addr_o,
  input logic [31:0]        data_wdata_o,
  input logic [3:0]         data_be_o,
  input logic               rsp_valid_o,
  input logic               busy_o,
  input logic [31:0]        rsp_rdata_o
);
  import lsu_pkg::*;

  int          errors = 0;
  logic        grant;
  logic        seen_req;
  // Second transfer of a split access is on the bus
  logic        in_second;
  logic [2:0]  out_cnt;
  logic [31:0] acc_addr;
  logic [3:0]  exp_be;
  logic [31:0] exp_addr;
  logic        exp_last;
  logic [31:0] lane_mask;
  logic [31:0] exp_wdata;
  // Expected results in acceptance order
  logic [31:0] exp_data [4];
  logic        exp_load [4];
  logic [1:0]  wr_ptr;
  logic [1:0]  rd_ptr;
  logic [2:0]  pending;

  // Memory holds the inverted low address byte
  function automatic logic [7:0] mem_byte(input logic [31:0] addr);
    return ~addr[7:0];
  endfunction

  function automatic logic [31:0] load_value(input logic [31:0] a, input lsu_size_e size,
                                             input logic sext);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = mem_byte(a);
    b1 = mem_byte(a + 1);
    case (size)
      size_byte: return {{24{sext & b0[7]}}, b0};
      size_half: return {{16{sext & b1[7]}}, b1, b0};
      default:   return {mem_byte(a + 3), mem_byte(a + 2), b1, b0};
    endcase
  endfunction

  //////////////////////////////
  // Expected bus transfer
  //////////////////////////////
  always_comb begin
    int k;
    int acc_off;
    int nbytes;
    acc_addr = req_op_a_i + req_op_b_i;
    acc_off  = int'(acc_addr[1:0]);
    nbytes   = (req_size_i == size_byte) ? 1 : (req_size_i == size_half) ? 2 : 4;
    exp_addr = {acc_addr[31:2], 2'b00} + (in_second ? 32'd4 : 32'd0);
    // Last transfer unless the access runs past the top lane
    exp_last = in_second || (acc_off + nbytes <= 4);
    // Lane i carries access byte k when k lies inside the access
    for (int i = 0; i < 4; i++) begin
      k = (in_second ? 4 : 0) + i - acc_off;
      exp_be[i] = (k >= 0) && (k < nbytes);
      lane_mask[8*i +: 8] = {8{exp_be[i]}};
      exp_wdata[8*i +: 8] = exp_be[i] ? req_wdata_i[8*(k & 3) +: 8] : 8'h00;
    end
  end

  assign grant = data_req_o && data_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_req  <= 1'b0;
      in_second <= 1'b0;
      out_cnt   <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      pending   <= '0;
    end else begin
      if (req_valid_i) seen_req <= 1'b1;
      if (!req_valid_i) in_second <= 1'b0;
      else if (grant) in_second <= !exp_last;
      out_cnt <= out_cnt + 3'(grant) - 3'(data_rvalid_i);
      if (req_ready_o) wr_ptr <= wr_ptr + 1'b1;
      if (rsp_valid_o) rd_ptr <= rd_ptr + 1'b1;
      pending <= pending + 3'(req_ready_o) - 3'(rsp_valid_o);
    end
  end

  // Result computed when the access is accepted
  always_ff @(posedge clk) begin
    if (req_ready_o) begin
      exp_data[wr_ptr] <= load_value(acc_addr, req_size_i, req_sext_i);
      exp_load[wr_ptr] <= !req_we_i;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  idle_after_reset_a: assert property (@(posedge clk) (!seen_req && !req_valid_i) |->
      !data_req_o && !req_ready_o && !rsp_valid_o && !busy_o)
    else begin
      $error("outputs active before the first request");
      errors++;
    end

  // Bus request follows the request while the counter has room
  req_a: assert property (@(posedge clk) disable iff (!rst_n)
      data_req_o == (req_valid_i && (out_cnt < 3'(lsu_depth))))
    else begin
      $error("error %0t data_req_o got %b expected %b", $time, $sampled(data_req_o),
             $sampled(req_valid_i && (out_cnt < 3'(lsu_depth))));
      errors++;
    end

  busy_a: assert property (@(posedge clk) disable iff (!rst_n)
      busy_o == (req_valid_i || (out_cnt != 3'd0)))
    else begin
      $error("error %0t busy_o got %b expected %b", $time, $sampled(busy_o),
             $sampled(req_valid_i || (out_cnt != 3'd0)));
      errors++;
    end

  addr_a: assert property (@(posedge clk) disable iff (!rst_n) grant |-> data_addr_o == exp_addr)
    else begin
      $error("error %0t data_addr_o got %h expected %h", $time, $sampled(data_addr_o),
             $sampled(exp_addr));
      errors++;
    end

  we_a: assert property (@(posedge clk) disable iff (!rst_n) grant |-> data_we_o == req_we_i)
    else begin
      $error("error %0t data_we_o got %b expected %b", $time, $sampled(data_we_o),
             $sampled(req_we_i));
      errors++;
    end

  be_a: assert property (@(posedge clk) disable iff (!rst_n) grant |-> data_be_o == exp_be)
    else begin
      $error("error %0t data_be_o got %b expected %b", $time, $sampled(data_be_o),
             $sampled(exp_be));
      errors++;
    end

  wdata_a: assert property (@(posedge clk) disable iff (!rst_n)
      grant && data_we_o |-> (data_wdata_o & lane_mask) == exp_wdata)
    else begin
      $error("error %0t data_wdata_o got %h expected %h", $time,
             $sampled(data_wdata_o & lane_mask), $sampled(exp_wdata));
      errors++;
    end

  last_a: assert property (@(posedge clk) disable iff (!rst_n) grant |-> req_ready_o == exp_last)
    else begin
      $error("error %0t req_ready_o got %b expected %b", $time, $sampled(req_ready_o),
             $sampled(exp_last));
      errors++;
    end

  // Request held while waiting for grant
  stable_a: assert property (@(posedge clk) disable iff (!rst_n) data_req_o && !data_gnt_i |=>
      data_req_o && $stable(data_addr_o) && $stable(data_be_o) && $stable(data_wdata_o))
    else begin
      $error("bus request changed while waiting for grant");
      errors++;
    end

  depth_a: assert property (@(posedge clk) disable iff (!rst_n) out_cnt <= 3'd2)
    else begin
      $error("more than two transfers outstanding");
      errors++;
    end

  one_result_a: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid_o |-> pending != 0)
    else begin
      $error("result raised with no accepted access");
      errors++;
    end

  rdata_a: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid_o && exp_load[rd_ptr] |-> rsp_rdata_o == exp_data[rd_ptr])
    else begin
      $error("error %0t rsp_rdata_o got %h expected %h", $time, $sampled(rsp_rdata_o),
             $sampled(exp_data[rd_ptr]));
      errors++;
    end

endmodule

bind lsu_top lsu_top_asserts asserts_i (.*);

// File: tb/tb_lsu_top.sv
`timescale 1ns/1ps
//////////////////////////////
// Load/store unit testbench
// Random grant memory model, access sweeps and verdict
//////////////////////////////
module tb_lsu_top;
  import lsu_pkg::*;

  localparam int wait_limit = 200;

  logic        clk, rst_n, req_valid_i, req_sext_i, req_we_i;
  logic        req_ready_o, data_req_o, data_we_o, rsp_valid_o, busy_o;
  logic        data_gnt_i, data_rvalid_i;
  logic [31:0] req_op_a_i, req_op_b_i, req_wdata_i, data_rdata_i;
  logic [31:0] data_addr_o, data_wdata_o, rsp_rdata_o;
  logic [3:0]  data_be_o;
  lsu_size_e   req_size_i;
  integer      seed = 32'h8bd81199;
  int          accepted = 0;
  int          results = 0;
  int          passed = 0;
  int          failed = 0;
  int          cyc = 0;
  bit          hung = 0;
  // Granted transfers waiting for their response
  logic [31:0] pend_addr [$];
  int          pend_due [$];

  lsu_top lsu_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Word at an aligned address, each byte the inverted low address byte
  function automatic logic [31:0] word_at(input logic [31:0] a);
    return ~{a[7:2], 2'd3, a[7:2], 2'd2, a[7:2], 2'd1, a[7:2], 2'd0};
  endfunction

  function automatic logic [31:0] rand_addr(input int off);
    return ($random(seed) & 32'hffff_fffc) | 32'(off);
  endfunction

  function automatic logic crosses(input int off, input int sz);
    return (sz == 2 && off != 0) || (sz == 1 && off == 3);
  endfunction

  //////////////////////////////
  // Memory responder
  //////////////////////////////
  initial begin
    int due;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    forever begin
      @(negedge clk);
      if (data_req_o && data_gnt_i) begin
        // One to three cycles after grant, in order
        due = cyc + 1 + {$random(seed)} % 3;
        if (pend_due.size() != 0 && due <= pend_due[$]) due = pend_due[$] + 1;
        pend_addr.push_back(data_addr_o);
        pend_due.push_back(due);
      end
      if (req_ready_o) accepted++;
      if (rsp_valid_o) results++;
      @(posedge clk);
      cyc++;
      #10;
      data_gnt_i    = ($random(seed) & 3) != 0;
      data_rvalid_i = (pend_due.size() != 0) && (pend_due[0] <= cyc);
      if (data_rvalid_i) begin
        data_rdata_i = word_at(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
    end
  end

  // Hold one access until accepted, operands split at random
  task automatic issue(input logic [31:0] addr, input lsu_size_e size, input logic sext,
                       input logic we);
    int waited;
    waited = 0;
    if (hung) return;
    req_op_b_i  = $random(seed);
    req_op_a_i  = addr - req_op_b_i;
    req_size_i  = size;
    req_sext_i  = sext;
    req_we_i    = we;
    req_wdata_i = $random(seed);
    req_valid_i = 1'b1;
    @(negedge clk);
    while (!req_ready_o && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready_o) begin
      $display("timeout, access at %h was never accepted", addr);
      hung = 1'b1;
    end
    @(posedge clk);
    #10;
  endtask

  task automatic sweep(input logic we, input logic split);
    for (int off = 0; off < 4; off++) begin
      for (int sz = 0; sz < 3; sz++) begin
        for (int sx = 0; sx < 2; sx++) begin
          if (crosses(off, sz) == split) issue(rand_addr(off), lsu_size_e'(sz), sx[0], we);
        end
      end
    end
  endtask

  // Drain results, then report the test
  task automatic finish_test(input string name, input int err_mark);
    int waited;
    waited = 0;
    req_valid_i = 1'b0;
    while (results != accepted && waited < wait_limit && !hung) begin
      @(posedge clk);
      #10;
      waited++;
    end
    if (results != accepted && !hung) begin
      $display("timeout, %0d results missing in %s", accepted - results, name);
      hung = 1'b1;
    end
    @(posedge clk);
    #10;
    if (!hung && lsu_top_i.asserts_i.errors == err_mark) begin
      passed++;
      $display("%s passed", name);
    end else begin
      failed++;
      $display("%s failed", name);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int mark;
    rst_n       = 1'b0;
    req_valid_i = 1'b0;
    req_op_a_i  = '0;
    req_op_b_i  = '0;
    req_size_i  = size_byte;
    req_sext_i  = 1'b0;
    req_we_i    = 1'b0;
    req_wdata_i = '0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    mark = lsu_top_i.asserts_i.errors;
    repeat (3) @(posedge clk);
    #10;
    finish_test("reset idle", mark);
    mark = lsu_top_i.asserts_i.errors;
    sweep(1'b0, 1'b0);
    finish_test("aligned loads", mark);
    mark = lsu_top_i.asserts_i.errors;
    sweep(1'b1, 1'b0);
    finish_test("aligned stores", mark);
    mark = lsu_top_i.asserts_i.errors;
    sweep(1'b0, 1'b1);
    finish_test("split loads", mark);
    mark = lsu_top_i.asserts_i.errors;
    sweep(1'b1, 1'b1);
    finish_test("split stores", mark);
    // Mixed back to back traffic under random grants
    mark = lsu_top_i.asserts_i.errors;
    repeat (32) begin
      issue(rand_addr({$random(seed)} % 4), lsu_size_e'({$random(seed)} % 3),
            $random(seed), $random(seed));
    end
    finish_test("random mix", mark);
    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
